//--- design/sha_pkg.sv
// SHA-256 word types, constants and round functions with digest word 0 held in bits 255:224
package sha_pkg;

	typedef logic [31:0]  word_t;      // One SHA word
	typedef logic [255:0] digest_t;    // Hash state, word a on top
	typedef logic [5:0]   round_idx_t; // Round 0..63

	////////////////////////////////////////
	// FIPS 180-4 constants
	////////////////////////////////////////

	localparam word_t K [64] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// Initial hash value, a..h
	localparam digest_t H0 = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	////////////////////////////////////////
	// Round helpers
	////////////////////////////////////////

	function automatic word_t rotr(word_t x, int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic word_t big_sigma0(word_t x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic word_t big_sigma1(word_t x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	function automatic word_t small_sigma0(word_t x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic word_t small_sigma1(word_t x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	function automatic word_t ch(word_t x, word_t y, word_t z);
		return (x & y) ^ (~x & z);
	endfunction

	function automatic word_t maj(word_t x, word_t y, word_t z);
		return (x & y) ^ (x & z) ^ (y & z);
	endfunction

	// W[t+16] from W[t+14], W[t+9], W[t+1], W[t]
	function automatic word_t sched_word(word_t w2, word_t w7, word_t w15, word_t w16);
		return small_sigma1(w2) + w7 + small_sigma0(w15) + w16;
	endfunction

endpackage

//--- design/miner_pkg.sv
// Miner types, APB byte address map and fixed 60-byte message words (needs sha_pkg compiled first)
package miner_pkg;

	typedef logic [31:0] nonce_t;    // Nonce, sent big-endian in word 14
	typedef logic [31:0] count_t;    // Nonce count or op count
	typedef logic [7:0]  apb_addr_t; // APB byte address

	// Register map
	localparam apb_addr_t ADDR_CTRL        = 8'h00; // Bit 0 starts a batch
	localparam apb_addr_t ADDR_NONCE_BASE  = 8'h04;
	localparam apb_addr_t ADDR_NONCE_COUNT = 8'h08;
	localparam apb_addr_t ADDR_STATUS      = 8'h0C; // Bit 0 busy
	localparam apb_addr_t ADDR_OP_COUNT    = 8'h10;
	localparam apb_addr_t ADDR_BEST_NONCE  = 8'h14;
	localparam apb_addr_t ADDR_BEST_DIGEST = 8'h20; // Eight words to 0x3C, MS word first

	// "abcdbcdecdefdefgefghfghighijhijkijkljklmklmnlmnomnopnopq"
	localparam sha_pkg::word_t PREFIX_WORDS [14] = '{
		32'h61626364, 32'h62636465, 32'h63646566, 32'h64656667,
		32'h65666768, 32'h66676869, 32'h6768696a, 32'h68696a6b,
		32'h696a6b6c, 32'h6a6b6c6d, 32'h6b6c6d6e, 32'h6c6d6e6f,
		32'h6d6e6f70, 32'h6e6f7071
	};

	// 56 prefix bytes plus 4 nonce bytes
	localparam logic [63:0] MSG_BITS = 64'd480;

endpackage

//--- design/nonce_dispatcher.sv
// Batch nonce issuer for NUM_LANES lanes; start is ignored while busy or when the count is zero
module nonce_dispatcher #(
	parameter int NUM_LANES = 4
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 start,
	input  miner_pkg::nonce_t    nonce_base,
	input  miner_pkg::count_t    nonce_count,
	input  logic [NUM_LANES-1:0] lane_idle,
	input  logic                 result_taken,
	output logic [NUM_LANES-1:0] lane_start,
	output miner_pkg::nonce_t    lane_nonce,
	output logic                 batch_start,
	output logic                 busy
);

	typedef enum logic [1:0] {IDLE, ISSUE, DRAIN} state_t;

	state_t               state;
	miner_pkg::nonce_t    next_nonce; // Nonce for the next idle lane
	miner_pkg::count_t    to_issue;   // Nonces not yet handed out
	miner_pkg::count_t    to_collect; // Results not yet drained
	logic                 accept;
	logic                 issue;
	logic [NUM_LANES-1:0] pick;

	assign accept = start && (state == IDLE) && (nonce_count != '0);
	assign pick   = lane_idle & (~lane_idle + 1'b1); // Lowest idle lane
	assign issue  = (state == ISSUE) && (|lane_idle);

	assign lane_start = issue ? pick : '0;
	assign lane_nonce = next_nonce; // Shared by all lanes
	assign busy       = (state != IDLE);

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= IDLE;
			batch_start <= 1'b0;
			next_nonce  <= '0;
			to_issue    <= '0;
			to_collect  <= '0;
		end else begin
			batch_start <= accept; // Tracker clears its best here
			case (state)
				IDLE: if (accept) begin
					next_nonce <= nonce_base;
					to_issue   <= nonce_count;
					to_collect <= nonce_count;
					state      <= ISSUE;
				end
				ISSUE: begin
					if (issue) begin
						next_nonce <= next_nonce + 1'b1;
						to_issue   <= to_issue - 1'b1;
						if (to_issue == 1)
							state <= DRAIN; // Last nonce out
					end
					if (result_taken)
						to_collect <= to_collect - 1'b1; // Early finishers
				end
				DRAIN: if (result_taken) begin
					to_collect <= to_collect - 1'b1;
					if (to_collect == 1)
						state <= IDLE; // busy drops next cycle
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

//--- design/hash_lane.sv
// One round per clock; result_valid is set 195 clocks after the edge that takes lane_start
module hash_lane (
	input  logic              clk,
	input  logic              reset,
	input  logic              lane_start,
	input  miner_pkg::nonce_t lane_nonce,
	input  logic              result_ack,
	output logic              lane_idle,
	output logic              result_valid,
	output sha_pkg::digest_t  result_digest,
	output miner_pkg::nonce_t result_nonce
);

	typedef enum logic [2:0] {IDLE, BLOCK0, BLOCK1, FINAL, DONE} phase_t;

	phase_t              phase;
	sha_pkg::round_idx_t round;
	logic                feed_fwd;  // 65th cycle of a compression
	sha_pkg::word_t      w [16];    // Schedule window with w[0] as W[t]
	sha_pkg::digest_t    work;      // a..h
	sha_pkg::digest_t    chain;     // Hash state entering this block
	sha_pkg::digest_t    sum_state; // chain + work per word
	sha_pkg::digest_t    work_next;
	logic [511:0]        block_next;
	logic                take;
	logic                rounding;
	logic                load_block;
	sha_pkg::word_t      a, b, c, d, e, f, g, h;
	sha_pkg::word_t      t1, t2;

	assign take       = (phase == IDLE) && lane_start;
	assign rounding   = (phase inside {BLOCK0, BLOCK1, FINAL}) && !feed_fwd;
	assign load_block = take || (feed_fwd && phase != FINAL);
	assign lane_idle  = (phase == IDLE);

	////////////////////////////////////////
	// Round datapath
	////////////////////////////////////////

	assign {a, b, c, d, e, f, g, h} = work;
	assign t1 = h + sha_pkg::big_sigma1(e) + sha_pkg::ch(e, f, g) + sha_pkg::K[round] + w[0];
	assign t2 = sha_pkg::big_sigma0(a) + sha_pkg::maj(a, b, c);
	assign work_next = {t1 + t2, a, b, c, d + t1, e, f, g};

	always_comb begin
		for (int i = 0; i < 8; i++)
			sum_state[255 - 32*i -: 32] = chain[255 - 32*i -: 32] + work[255 - 32*i -: 32];
	end

	// Next 512-bit block picked by the phase that is ending
	always_comb begin
		block_next = '0;
		case (phase)
			IDLE: begin // Prefix, nonce and pad bit
				for (int i = 0; i < 14; i++)
					block_next[511 - 32*i -: 32] = miner_pkg::PREFIX_WORDS[i];
				block_next[63:32] = lane_nonce;
				block_next[31:0]  = 32'h8000_0000;
			end
			BLOCK0: block_next[63:0] = miner_pkg::MSG_BITS; // Zeros then length
			default: block_next = {sum_state, 32'h8000_0000, 192'd0, 32'd256}; // Outer hash
		endcase
	end

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			phase        <= IDLE;
			round        <= '0;
			feed_fwd     <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			case (phase)
				IDLE: if (lane_start) begin
					phase    <= BLOCK0;
					round    <= '0;
					feed_fwd <= 1'b0;
				end
				BLOCK0, BLOCK1, FINAL: begin
					if (feed_fwd) begin
						feed_fwd <= 1'b0;
						case (phase)
							BLOCK0:  phase <= BLOCK1;
							BLOCK1:  phase <= FINAL;
							default: begin
								phase        <= DONE;
								result_valid <= 1'b1; // Held until acked
							end
						endcase
					end else begin
						round <= round + 1'b1; // Wraps to 0 after 63
						if (round == 6'd63)
							feed_fwd <= 1'b1;
					end
				end
				DONE: if (result_ack) begin
					result_valid <= 1'b0;
					phase        <= IDLE;
				end
				default: phase <= IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// Payload
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (load_block) begin
			for (int i = 0; i < 16; i++)
				w[i] <= block_next[511 - 32*i -: 32];
		end else if (rounding) begin
			for (int i = 0; i < 15; i++)
				w[i] <= w[i + 1];
			w[15] <= sha_pkg::sched_word(w[14], w[9], w[1], w[0]);
		end

		if (take) begin
			work         <= sha_pkg::H0;
			chain        <= sha_pkg::H0;
			result_nonce <= lane_nonce; // Travels with the digest
		end else if (rounding) begin
			work <= work_next;
		end else if (feed_fwd) begin
			case (phase)
				BLOCK0: begin // Second block continues the inner hash
					chain <= sum_state;
					work  <= sum_state;
				end
				BLOCK1: begin // Outer hash restarts from H0
					chain <= sha_pkg::H0;
					work  <= sha_pkg::H0;
				end
				default: result_digest <= sum_state;
			endcase
		end
	end

endmodule

//--- design/best_hash_tracker.sv
// Round-robin drain of up to 8 lanes; keeps the smallest digest per batch, ties to the lower nonce
module best_hash_tracker #(
	parameter int NUM_LANES = 4
) (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  batch_start,
	input  logic [NUM_LANES-1:0]                  result_valid,
	input  sha_pkg::digest_t [NUM_LANES-1:0]      result_digest,
	input  miner_pkg::nonce_t [NUM_LANES-1:0]     result_nonce,
	output logic [NUM_LANES-1:0]                  result_ack,
	output logic                                  result_taken,
	output sha_pkg::digest_t                      best_digest,
	output miner_pkg::nonce_t                     best_nonce,
	output miner_pkg::count_t                     op_count
);

	localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

	logic [PTR_W-1:0]  rr_ptr;  // First lane looked at
	logic [PTR_W-1:0]  sel_idx;
	logic              sel_hit;
	logic              take_new;
	sha_pkg::digest_t  sel_digest;
	miner_pkg::nonce_t sel_nonce;

	// First valid lane at or after rr_ptr
	always_comb begin
		int idx;
		sel_hit = 1'b0;
		sel_idx = '0;
		for (int k = 0; k < NUM_LANES; k++) begin
			idx = int'(rr_ptr) + k;
			if (idx >= NUM_LANES)
				idx = idx - NUM_LANES;
			if (!sel_hit && result_valid[idx]) begin
				sel_hit = 1'b1;
				sel_idx = PTR_W'(idx);
			end
		end
	end

	assign result_ack   = sel_hit ? (NUM_LANES'(1) << sel_idx) : '0;
	assign result_taken = sel_hit;
	assign sel_digest   = result_digest[sel_idx];
	assign sel_nonce    = result_nonce[sel_idx];
	assign take_new     = (sel_digest < best_digest) ||
	                      ((sel_digest == best_digest) && (sel_nonce < best_nonce));

	always_ff @(posedge clk) begin
		if (reset) begin
			rr_ptr      <= '0;
			best_digest <= '1;
			best_nonce  <= '0;
			op_count    <= '0;
		end else if (batch_start) begin
			best_digest <= '1; // op_count runs on across batches
		end else if (sel_hit) begin
			op_count <= op_count + 1'b1;
			rr_ptr   <= (sel_idx == PTR_W'(NUM_LANES - 1)) ? '0 : sel_idx + 1'b1;
			if (take_new) begin
				best_digest <= sel_digest;
				best_nonce  <= sel_nonce;
			end
		end
	end

endmodule

//--- design/miner_apb_regs.sv
// APB slave without wait states; word-aligned addresses only, CTRL reads as zero
module miner_apb_regs (
	input  logic                 clk,
	input  logic                 reset,
	input  miner_pkg::apb_addr_t paddr,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  sha_pkg::word_t       pwdata,
	input  logic                 busy,
	input  miner_pkg::count_t    op_count,
	input  miner_pkg::nonce_t    best_nonce,
	input  sha_pkg::digest_t     best_digest,
	output sha_pkg::word_t       prdata,
	output logic                 pready,
	output logic                 pslverr,
	output logic                 start,
	output miner_pkg::nonce_t    nonce_base,
	output miner_pkg::count_t    nonce_count
);

	logic       access;
	logic       hit_ctrl, hit_base, hit_count, hit_status;
	logic       hit_ops, hit_best_nonce, hit_digest;
	logic       read_only;
	logic       mapped;
	logic       wr_ok;
	logic [2:0] digest_word; // 0 is the top word

	assign access = psel && penable; // Access phase

	// Address decode
	assign hit_ctrl       = (paddr == miner_pkg::ADDR_CTRL);
	assign hit_base       = (paddr == miner_pkg::ADDR_NONCE_BASE);
	assign hit_count      = (paddr == miner_pkg::ADDR_NONCE_COUNT);
	assign hit_status     = (paddr == miner_pkg::ADDR_STATUS);
	assign hit_ops        = (paddr == miner_pkg::ADDR_OP_COUNT);
	assign hit_best_nonce = (paddr == miner_pkg::ADDR_BEST_NONCE);
	assign hit_digest     = (paddr >= miner_pkg::ADDR_BEST_DIGEST) &&
	                        (paddr <= miner_pkg::ADDR_BEST_DIGEST + 8'h1C) &&
	                        (paddr[1:0] == 2'b00);
	assign digest_word    = paddr[4:2];

	assign read_only = hit_status || hit_ops || hit_best_nonce || hit_digest;
	assign mapped    = hit_ctrl || hit_base || hit_count || read_only;

	assign pready  = 1'b1; // Never stalls
	assign pslverr = access && (!mapped || (pwrite && read_only));
	assign wr_ok   = access && pwrite && mapped && !read_only;
	assign start   = wr_ok && hit_ctrl && pwdata[0]; // One cycle wide

	always_ff @(posedge clk) begin
		if (reset) begin
			nonce_base  <= '0;
			nonce_count <= '0;
		end else if (wr_ok) begin
			if (hit_base)
				nonce_base <= pwdata;
			if (hit_count)
				nonce_count <= pwdata;
		end
	end

	// Read mux, quiet outside reads
	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			if (hit_base)            prdata = nonce_base;
			else if (hit_count)      prdata = nonce_count;
			else if (hit_status)     prdata = {31'd0, busy};
			else if (hit_ops)        prdata = op_count;
			else if (hit_best_nonce) prdata = best_nonce;
			else if (hit_digest)     prdata = best_digest[255 - 32*digest_word -: 32];
		end
	end

endmodule

//--- design/sha_miner_top.sv
// Nonce search engine top with APB control; NUM_LANES from 1 to 8
module sha_miner_top #(
	parameter int NUM_LANES = 4
) (
	input  logic                 clk,
	input  logic                 reset,
	input  miner_pkg::apb_addr_t paddr,
	input  logic                 psel,
	input  logic                 penable,
	input  logic                 pwrite,
	input  sha_pkg::word_t       pwdata,
	output sha_pkg::word_t       prdata,
	output logic                 pready,
	output logic                 pslverr
);

	logic                                 start;
	logic                                 busy;
	logic                                 batch_start;
	logic                                 result_taken;
	miner_pkg::nonce_t                    nonce_base;
	miner_pkg::count_t                    nonce_count;
	miner_pkg::nonce_t                    lane_nonce;  // Shared issue bus
	logic [NUM_LANES-1:0]                 lane_start;
	logic [NUM_LANES-1:0]                 lane_idle;
	logic [NUM_LANES-1:0]                 result_valid;
	logic [NUM_LANES-1:0]                 result_ack;
	sha_pkg::digest_t [NUM_LANES-1:0]     result_digest;
	miner_pkg::nonce_t [NUM_LANES-1:0]    result_nonce;
	miner_pkg::count_t                    op_count;
	miner_pkg::nonce_t                    best_nonce;
	sha_pkg::digest_t                     best_digest;

	miner_apb_regs u_regs (
		.clk(clk), .reset(reset),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .busy(busy), .op_count(op_count),
		.best_nonce(best_nonce), .best_digest(best_digest),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.start(start), .nonce_base(nonce_base), .nonce_count(nonce_count)
	);

	nonce_dispatcher #(.NUM_LANES(NUM_LANES)) u_dispatch (
		.clk(clk), .reset(reset), .start(start),
		.nonce_base(nonce_base), .nonce_count(nonce_count),
		.lane_idle(lane_idle), .result_taken(result_taken),
		.lane_start(lane_start), .lane_nonce(lane_nonce),
		.batch_start(batch_start), .busy(busy)
	);

	// Identical lanes
	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		hash_lane u_lane (
			.clk(clk), .reset(reset),
			.lane_start(lane_start[i]), .lane_nonce(lane_nonce),
			.result_ack(result_ack[i]), .lane_idle(lane_idle[i]),
			.result_valid(result_valid[i]), .result_digest(result_digest[i]),
			.result_nonce(result_nonce[i])
		);
	end

	best_hash_tracker #(.NUM_LANES(NUM_LANES)) u_tracker (
		.clk(clk), .reset(reset), .batch_start(batch_start),
		.result_valid(result_valid), .result_digest(result_digest),
		.result_nonce(result_nonce), .result_ack(result_ack),
		.result_taken(result_taken), .best_digest(best_digest),
		.best_nonce(best_nonce), .op_count(op_count)
	);

endmodule

//--- dv/sha_miner_checker.sv
// Bound into sha_miner_top and reads its internal busy and batch_start nets by name
module sha_miner_checker (
	input logic clk,
	input logic reset,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic pslverr,
	input logic busy,
	input logic batch_start
);
	timeunit 1ns;
	timeprecision 1ps;

	// No wait states ever
	pready_high: assert property (@(posedge clk) disable iff (reset) pready)
		else $error("pready went low");

	// Error response belongs to the access phase
	pslverr_in_access: assert property (@(posedge clk) disable iff (reset)
		pslverr |-> (psel && penable))
		else $error("pslverr outside an access phase");

	// busy only rises together with an accepted start
	busy_needs_start: assert property (@(posedge clk) disable iff (reset)
		$rose(busy) |-> batch_start)
		else $error("busy rose without an accepted start");

endmodule

bind sha_miner_top sha_miner_checker u_checker (
	.clk(clk), .reset(reset), .psel(psel), .penable(penable),
	.pready(pready), .pslverr(pslverr), .busy(busy), .batch_start(batch_start)
);

//--- dv/sha_miner_tb.sv
// Testbench for 4 lanes; three-clock APB transfers with read data taken on the falling edge
module sha_miner_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int          NUM_LANES = 4;
	localparam int unsigned SEED      = 32'h6fea_aaf0;

	// Message text before the nonce in big-endian order
	localparam logic [447:0] PREFIX_TEXT =
		"abcdbcdecdefdefgefghfghighijhijkijkljklmklmnlmnomnopnopq";

	// Clocks per batch from 195 per lane pass plus slack
	function automatic int batch_cycles(int count);
		return ((count + NUM_LANES - 1) / NUM_LANES) * 200;
	endfunction

	// Batches of 1, 10 and 6 nonces
	localparam int CYCLE_LIMIT = batch_cycles(1) + batch_cycles(10) + batch_cycles(6) + 500;

	logic                 clk;
	logic                 reset;
	miner_pkg::apb_addr_t paddr;
	logic                 psel;
	logic                 penable;
	logic                 pwrite;
	sha_pkg::word_t       pwdata;
	sha_pkg::word_t       prdata;
	logic                 pready;
	logic                 pslverr;
	int                   cycle_count = 0;

	sha_miner_top #(.NUM_LANES(NUM_LANES)) u_dut (
		.clk(clk), .reset(reset), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	always @(posedge clk) cycle_count <= cycle_count + 1;

	initial begin
		wait (cycle_count >= CYCLE_LIMIT);
		$display("Timeout: no end of test after %0d clock cycles", CYCLE_LIMIT);
		$display("Some tests failed");
		$fatal(1, "run stopped by the cycle limit");
	end

	////////////////////////////////////////
	// Reference double SHA-256
	////////////////////////////////////////

	function automatic sha_pkg::digest_t compress(sha_pkg::digest_t state, logic [511:0] block);
		sha_pkg::word_t   w [64];
		sha_pkg::word_t   v [8];
		sha_pkg::word_t   t1;
		sha_pkg::word_t   t2;
		sha_pkg::digest_t out;
		for (int t = 0; t < 16; t++)
			w[t] = block[511 - 32*t -: 32];
		for (int t = 16; t < 64; t++) // Full schedule up front
			w[t] = sha_pkg::small_sigma1(w[t-2]) + w[t-7] +
			       sha_pkg::small_sigma0(w[t-15]) + w[t-16];
		for (int i = 0; i < 8; i++)
			v[i] = state[255 - 32*i -: 32];
		for (int t = 0; t < 64; t++) begin
			t1 = v[7] + sha_pkg::big_sigma1(v[4]) + sha_pkg::ch(v[4], v[5], v[6]) +
			     sha_pkg::K[t] + w[t];
			t2 = sha_pkg::big_sigma0(v[0]) + sha_pkg::maj(v[0], v[1], v[2]);
			for (int i = 7; i > 0; i--)
				v[i] = v[i-1]; // Shift a..g down
			v[4] = v[4] + t1; // New e from old d
			v[0] = t1 + t2;
		end
		for (int i = 0; i < 8; i++)
			out[255 - 32*i -: 32] = state[255 - 32*i -: 32] + v[i];
		return out;
	endfunction

	function automatic sha_pkg::digest_t ref_double_sha(miner_pkg::nonce_t nonce);
		sha_pkg::digest_t inner;
		inner = compress(sha_pkg::H0, {PREFIX_TEXT, nonce, 32'h8000_0000});
		inner = compress(inner, {448'd0, 64'd480}); // Length block of 60 bytes
		return compress(sha_pkg::H0, {inner, 32'h8000_0000, 160'd0, 64'd256});
	endfunction

	// Smallest digest over a range with ties to the lower nonce
	task automatic best_of_range(input miner_pkg::nonce_t base, input miner_pkg::count_t count,
	                             output sha_pkg::digest_t best, output miner_pkg::nonce_t nonce);
		sha_pkg::digest_t  h;
		miner_pkg::nonce_t cand;
		best  = '1;
		nonce = '0;
		for (int unsigned i = 0; i < count; i++) begin
			cand = base + miner_pkg::nonce_t'(i); // Wraps like the DUT
			h    = ref_double_sha(cand);
			if (h < best || (h == best && cand < nonce)) begin
				best  = h;
				nonce = cand;
			end
		end
	endtask

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////

	task automatic check_word(input sha_pkg::word_t got, input sha_pkg::word_t exp,
	                          input string what);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("Some tests failed");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_digest(input sha_pkg::digest_t got, input sha_pkg::digest_t exp,
	                            input string what);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			$display("Some tests failed");
			$fatal(1, "digest mismatch");
		end
	endtask

	task automatic check_count(input miner_pkg::count_t got, input miner_pkg::count_t exp,
	                           input string what);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			$display("Some tests failed");
			$fatal(1, "count mismatch");
		end
	endtask

	////////////////////////////////////////
	// APB tasks
	////////////////////////////////////////

	task automatic apb_write(input miner_pkg::apb_addr_t addr, input sha_pkg::word_t data,
	                         output logic err);
		@(posedge clk); // Setup phase
		paddr   <= addr;
		pwrite  <= 1'b1;
		pwdata  <= data;
		psel    <= 1'b1;
		penable <= 1'b0;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		err = pslverr;
		@(posedge clk); // Write lands here
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_read(input miner_pkg::apb_addr_t addr, output sha_pkg::word_t data,
	                        output logic err);
		@(posedge clk);
		paddr   <= addr;
		pwrite  <= 1'b0;
		psel    <= 1'b1;
		penable <= 1'b0;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk); // Mid access phase
		data = prdata;
		err  = pslverr;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic write_ok(input miner_pkg::apb_addr_t addr, input sha_pkg::word_t data);
		logic err;
		apb_write(addr, data, err);
		check_word(sha_pkg::word_t'(err), '0, $sformatf("pslverr on write to %h", addr));
	endtask

	task automatic read_ok(input miner_pkg::apb_addr_t addr, output sha_pkg::word_t data);
		logic err;
		apb_read(addr, data, err);
		check_word(sha_pkg::word_t'(err), '0, $sformatf("pslverr on read of %h", addr));
	endtask

	task automatic read_digest(output sha_pkg::digest_t d);
		sha_pkg::word_t word;
		for (int i = 0; i < 8; i++) begin
			read_ok(miner_pkg::ADDR_BEST_DIGEST + miner_pkg::apb_addr_t'(4*i), word);
			d[255 - 32*i -: 32] = word; // Word 0 on top
		end
	endtask

	task automatic wait_batch_done();
		sha_pkg::word_t status;
		do
			read_ok(miner_pkg::ADDR_STATUS, status);
		while (status[0]);
	endtask

	task automatic run_batch(input miner_pkg::nonce_t base, input miner_pkg::count_t count);
		write_ok(miner_pkg::ADDR_NONCE_BASE, base);
		write_ok(miner_pkg::ADDR_NONCE_COUNT, count);
		write_ok(miner_pkg::ADDR_CTRL, 32'h1);
		wait_batch_done();
	endtask

	task automatic check_results(input miner_pkg::nonce_t base, input miner_pkg::count_t count,
	                             input miner_pkg::count_t ops, input string tag);
		sha_pkg::digest_t  got_d;
		sha_pkg::digest_t  exp_d;
		miner_pkg::nonce_t exp_n;
		sha_pkg::word_t    rdata;
		best_of_range(base, count, exp_d, exp_n);
		read_digest(got_d);
		check_digest(got_d, exp_d, {tag, " BEST_DIGEST"});
		read_ok(miner_pkg::ADDR_BEST_NONCE, rdata);
		check_word(rdata, exp_n, {tag, " BEST_NONCE"});
		read_ok(miner_pkg::ADDR_OP_COUNT, rdata);
		check_count(miner_pkg::count_t'(rdata), ops, {tag, " OP_COUNT"});
	endtask

	////////////////////////////////////////
	// Stimulus and checks
	////////////////////////////////////////

	initial begin
		sha_pkg::word_t    rdata;
		sha_pkg::digest_t  got_d;
		miner_pkg::nonce_t base;
		miner_pkg::count_t ops;
		logic              err;

		paddr   = '0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		pwdata  = '0;
		reset   = 1'b1;
		void'($urandom(SEED)); // Seed for every later draw
		ops     = '0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		// Reset values
		read_ok(miner_pkg::ADDR_STATUS, rdata);
		check_word(rdata, 32'h0, "STATUS after reset");
		read_ok(miner_pkg::ADDR_OP_COUNT, rdata);
		check_count(miner_pkg::count_t'(rdata), '0, "OP_COUNT after reset");
		read_ok(miner_pkg::ADDR_BEST_NONCE, rdata);
		check_word(rdata, 32'h0, "BEST_NONCE after reset");
		read_digest(got_d);
		check_digest(got_d, '1, "BEST_DIGEST after reset");

		// Single nonce 0
		run_batch(32'h0, 32'd1);
		ops += 1;
		check_results(32'h0, 32'd1, ops, "single");

		// Ten nonces from a random base
		base = $urandom();
		run_batch(base, 32'd10);
		ops += 10;
		check_results(base, 32'd10, ops, "ten");

		// Start while busy is dropped
		base = $urandom();
		write_ok(miner_pkg::ADDR_NONCE_BASE, base);
		write_ok(miner_pkg::ADDR_NONCE_COUNT, 32'd6);
		write_ok(miner_pkg::ADDR_CTRL, 32'h1);
		read_ok(miner_pkg::ADDR_STATUS, rdata);
		check_word(rdata, 32'h1, "STATUS during batch");
		write_ok(miner_pkg::ADDR_CTRL, 32'h1); // Ignored
		wait_batch_done();
		ops += 6;
		check_results(base, 32'd6, ops, "busy start");

		// Zero count start is dropped too
		write_ok(miner_pkg::ADDR_NONCE_COUNT, 32'd0);
		write_ok(miner_pkg::ADDR_CTRL, 32'h1);
		read_ok(miner_pkg::ADDR_STATUS, rdata);
		check_word(rdata, 32'h0, "STATUS after zero count start");
		check_results(base, 32'd6, ops, "zero count");

		// Register readback and error responses
		base = $urandom();
		write_ok(miner_pkg::ADDR_NONCE_BASE, base);
		read_ok(miner_pkg::ADDR_NONCE_BASE, rdata);
		check_word(rdata, base, "NONCE_BASE readback");
		base = $urandom();
		write_ok(miner_pkg::ADDR_NONCE_COUNT, base);
		read_ok(miner_pkg::ADDR_NONCE_COUNT, rdata);
		check_word(rdata, base, "NONCE_COUNT readback");
		apb_read(8'h18, rdata, err); // Hole in the map
		check_word(sha_pkg::word_t'(err), 32'h1, "pslverr on unmapped read");
		apb_write(8'h40, 32'h1234_5678, err);
		check_word(sha_pkg::word_t'(err), 32'h1, "pslverr on unmapped write");
		apb_write(miner_pkg::ADDR_OP_COUNT, 32'hdead_beef, err);
		check_word(sha_pkg::word_t'(err), 32'h1, "pslverr on OP_COUNT write");
		read_ok(miner_pkg::ADDR_OP_COUNT, rdata);
		check_count(miner_pkg::count_t'(rdata), ops, "OP_COUNT after write attempt");

		$display("All tests passed");
		$finish;
	end

endmodule

//--- list.f
design/sha_pkg.sv
design/miner_pkg.sv
design/nonce_dispatcher.sv
design/hash_lane.sv
design/best_hash_tracker.sv
design/miner_apb_regs.sv
design/sha_miner_top.sv
dv/sha_miner_checker.sv
dv/sha_miner_tb.sv

//--- Makefile
# Verilator flow for the SHA-256 nonce search engine
# Override any variable on the command line, e.g. make sim OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= sha_miner_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
